//--- src/speed_pkg.sv
`default_nettype none

package speed_pkg;

    // port count and bus geometry
    localparam int PORT_NUM = 4;
    localparam int DATA_W = 32;
    localparam int ADDR_W = 9;
    localparam int STRB_W = DATA_W / 8;
    localparam int WORD_LSB = $clog2(STRB_W);
    localparam int CFG_WORDS = 2;

    // word counts and index widths of the two per-port windows
    localparam int CFG_NUM = PORT_NUM * CFG_WORDS;
    localparam int CFG_IDX_W = $clog2(CFG_NUM);
    localparam int RES_IDX_W = $clog2(PORT_NUM);

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [CFG_WORDS*DATA_W-1:0] port_cfg_t;
    typedef logic [DATA_W-1:0] port_res_t;
    typedef port_cfg_t [PORT_NUM-1:0] cfg_array_t;
    typedef port_res_t [PORT_NUM-1:0] res_array_t;

    // register map, byte addresses in a 512-byte window
    localparam addr_t ADDR_BUSY = 9'h000;
    localparam addr_t ADDR_START = 9'h004;
    localparam addr_t ADDR_DURATION = 9'h008;
    localparam addr_t ADDR_CFG_BASE = 9'h100;
    localparam addr_t ADDR_RES_BASE = 9'h180;

    // test timing; a tick would be 1 ms of clock in hardware
    localparam int DURATION_W = 13;
    localparam int TICKS_W = 16;
    localparam int TICK_CYCLES = 16;
    localparam int CYC_W = $clog2(TICK_CYCLES);
    localparam int DRAIN_TICKS = 2;
    localparam int DRAIN_W = $clog2(DRAIN_TICKS + 1);
    localparam logic [7:0] START_KEY = 8'hFF;

    typedef enum logic [1:0] {
        WAIT_READY,
        IDLE,
        RUN,
        DRAIN
    } seq_state_t;

endpackage

`default_nettype wire

//--- src/reg_wr_if.sv
`default_nettype none

// one decoded register write, valid while wr_en is high
interface reg_wr_if;
    import speed_pkg::*;

    logic wr_en;
    addr_t addr;
    data_t data;
    logic [STRB_W-1:0] strb;

    // bus front end side
    modport source (output wr_en, addr, data, strb);
    // register bank side
    modport sink (input wr_en, addr, data, strb);

endinterface

`default_nettype wire

//--- src/axi_lite_slave.sv
`default_nettype none

module axi_lite_slave (
    input  logic                          S_AXI_ACLK,
    input  logic                          S_AXI_ARESETN,
    // write address and data
    input  speed_pkg::addr_t              S_AXI_AWADDR,
    input  logic                          S_AXI_AWVALID,
    output logic                          S_AXI_AWREADY,
    input  speed_pkg::data_t              S_AXI_WDATA,
    input  logic [speed_pkg::STRB_W-1:0]  S_AXI_WSTRB,
    input  logic                          S_AXI_WVALID,
    output logic                          S_AXI_WREADY,
    // write response
    output logic [1:0]                    S_AXI_BRESP,
    output logic                          S_AXI_BVALID,
    input  logic                          S_AXI_BREADY,
    // read address and data
    input  speed_pkg::addr_t              S_AXI_ARADDR,
    input  logic                          S_AXI_ARVALID,
    output logic                          S_AXI_ARREADY,
    output speed_pkg::data_t              S_AXI_RDATA,
    output logic [1:0]                    S_AXI_RRESP,
    output logic                          S_AXI_RVALID,
    input  logic                          S_AXI_RREADY,
    // register bank side
    reg_wr_if.source                      wr,
    output speed_pkg::addr_t              rd_addr,
    input  speed_pkg::data_t              rd_data
);
    import speed_pkg::*;

    logic wr_ready;
    logic bvalid;
    logic arready;
    logic rvalid;
    addr_t awaddr_q;
    addr_t araddr_q;
    data_t rdata_q;
    logic rd_accept;

    // one ready pulse for both AW and W, only when no response is pending
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            wr_ready <= 1'b0;
        end
        else
        begin
            wr_ready <= !wr_ready && !bvalid && S_AXI_AWVALID && S_AXI_WVALID;
        end
    end

    // address is captured on the same edge that raises ready
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!wr_ready && !bvalid && S_AXI_AWVALID && S_AXI_WVALID)
        begin
            awaddr_q <= S_AXI_AWADDR;
        end
    end

    // write strobe to the register bank in the ready cycle
    // data and strobes are still held by the master here
    assign wr.wr_en = wr_ready;
    assign wr.addr = awaddr_q;
    assign wr.data = S_AXI_WDATA;
    assign wr.strb = S_AXI_WSTRB;

    // response follows the ready pulse and waits for BREADY
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            bvalid <= 1'b0;
        end
        else if (wr_ready)
        begin
            bvalid <= 1'b1;
        end
        else if (S_AXI_BREADY)
        begin
            bvalid <= 1'b0;
        end
    end

    // read address accepted one edge after ARVALID, single outstanding
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            arready <= 1'b0;
        end
        else
        begin
            arready <= !arready && !rvalid && S_AXI_ARVALID;
        end
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!arready && !rvalid && S_AXI_ARVALID)
        begin
            araddr_q <= S_AXI_ARADDR;
        end
    end

    assign rd_addr = araddr_q;
    assign rd_accept = arready && S_AXI_ARVALID;

    // read data sampled from the bank when the address is accepted
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (rd_accept)
        begin
            rdata_q <= rd_data;
        end
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            rvalid <= 1'b0;
        end
        else if (rd_accept)
        begin
            rvalid <= 1'b1;
        end
        else if (S_AXI_RREADY)
        begin
            rvalid <= 1'b0;
        end
    end

    assign S_AXI_AWREADY = wr_ready;
    assign S_AXI_WREADY = wr_ready;
    assign S_AXI_BVALID = bvalid;
    // always OKAY
    assign S_AXI_BRESP = 2'b00;
    assign S_AXI_ARREADY = arready;
    assign S_AXI_RVALID = rvalid;
    assign S_AXI_RDATA = rdata_q;
    assign S_AXI_RRESP = 2'b00;

endmodule

`default_nettype wire

//--- src/ctrl_regs.sv
`default_nettype none

module ctrl_regs (
    input  logic                              S_AXI_ACLK,
    input  logic                              S_AXI_ARESETN,
    reg_wr_if.sink                            wr,
    input  speed_pkg::addr_t                  rd_addr,
    output speed_pkg::data_t                  rd_data,
    // sequencer side
    output logic                              start_req,
    output logic [speed_pkg::DURATION_W-1:0]  duration,
    input  logic                              busy,
    input  logic [speed_pkg::TICKS_W-1:0]     elapsed,
    input  speed_pkg::res_array_t             results,
    // per-port configuration out to the testers
    output speed_pkg::cfg_array_t             port_config
);
    import speed_pkg::*;

    logic [CFG_NUM-1:0][DATA_W-1:0] cfg_q;
    logic [DURATION_W-1:0] duration_q;

    addr_t wr_cfg_off;
    logic wr_cfg_hit;
    logic [CFG_IDX_W-1:0] wr_cfg_idx;
    addr_t rd_cfg_off;
    addr_t rd_res_off;
    logic rd_cfg_hit;
    logic rd_res_hit;

    // offsets into the config window; a wrap below the base fails the >= test
    assign wr_cfg_off = wr.addr - ADDR_CFG_BASE;
    assign wr_cfg_hit = (wr.addr >= ADDR_CFG_BASE) &&
                        (wr_cfg_off < addr_t'(CFG_NUM * STRB_W));
    assign wr_cfg_idx = wr_cfg_off[WORD_LSB +: CFG_IDX_W];

    // start key: byte lane 0 strobed and all ones
    // busy is checked by the sequencer, not here
    assign start_req = wr.wr_en && (wr.addr == ADDR_START) &&
                       wr.strb[0] && (wr.data[7:0] == START_KEY);

    // duration, only the low 13 bits exist
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            duration_q <= '0;
        end
        else if (wr.wr_en && (wr.addr == ADDR_DURATION))
        begin
            if (wr.strb[0])
            begin
                duration_q[7:0] <= wr.data[7:0];
            end
            if (wr.strb[1])
            begin
                duration_q[DURATION_W-1:8] <= wr.data[DURATION_W-1:8];
            end
        end
    end

    // configuration words, byte lanes follow the strobes
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            cfg_q <= '0;
        end
        else if (wr.wr_en && wr_cfg_hit)
        begin
            for (int b = 0; b < STRB_W; b++)
            begin
                if (wr.strb[b])
                begin
                    cfg_q[wr_cfg_idx][b*8 +: 8] <= wr.data[b*8 +: 8];
                end
            end
        end
    end

    assign duration = duration_q;
    // word 0 of port 0 lands in the low bits
    assign port_config = cfg_array_t'(cfg_q);

    // read decode
    assign rd_cfg_off = rd_addr - ADDR_CFG_BASE;
    assign rd_res_off = rd_addr - ADDR_RES_BASE;
    assign rd_cfg_hit = (rd_addr >= ADDR_CFG_BASE) &&
                        (rd_cfg_off < addr_t'(CFG_NUM * STRB_W));
    assign rd_res_hit = (rd_addr >= ADDR_RES_BASE) &&
                        (rd_res_off < addr_t'(PORT_NUM * STRB_W));

    always_comb
    begin
        if (rd_addr == ADDR_BUSY)
        begin
            rd_data = {{(DATA_W-1){1'b0}}, busy};
        end
        else if (rd_addr == ADDR_DURATION)
        begin
            // reads back elapsed ticks, not the programmed value
            rd_data = {{(DATA_W-TICKS_W){1'b0}}, elapsed};
        end
        else if (rd_cfg_hit)
        begin
            rd_data = cfg_q[rd_cfg_off[WORD_LSB +: CFG_IDX_W]];
        end
        else if (rd_res_hit)
        begin
            rd_data = results[rd_res_off[WORD_LSB +: RES_IDX_W]];
        end
        else
        begin
            // start register and holes read as zero
            rd_data = '0;
        end
    end

endmodule

`default_nettype wire

//--- src/test_sequencer.sv
`default_nettype none

module test_sequencer (
    input  logic                              S_AXI_ACLK,
    input  logic                              S_AXI_ARESETN,
    input  logic                              start_req,
    input  logic [speed_pkg::DURATION_W-1:0]  duration,
    input  logic [speed_pkg::PORT_NUM-1:0]    gen_ready,
    input  logic [speed_pkg::PORT_NUM-1:0]    check_ready,
    input  speed_pkg::res_array_t             check_results,
    output logic                              busy,
    output logic [speed_pkg::TICKS_W-1:0]     elapsed,
    output speed_pkg::res_array_t             results,
    output logic [speed_pkg::PORT_NUM-1:0]    start,
    output logic [speed_pkg::PORT_NUM-1:0]    stop
);
    import speed_pkg::*;

    seq_state_t state;
    logic start_q;
    logic stop_q;
    logic [CYC_W-1:0] cyc_cnt;
    logic [DRAIN_W-1:0] drain_cnt;
    logic tick_done;
    logic [TICKS_W-1:0] elapsed_nxt;
    logic [DRAIN_W-1:0] drain_nxt;

    // last cycle of a tick
    assign tick_done = (cyc_cnt == CYC_W'(TICK_CYCLES - 1));
    assign elapsed_nxt = elapsed + 1'b1;
    assign drain_nxt = drain_cnt + 1'b1;

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            state <= WAIT_READY;
            start_q <= 1'b0;
            stop_q <= 1'b0;
            cyc_cnt <= '0;
            drain_cnt <= '0;
            elapsed <= '0;
            results <= '0;
        end
        else
        begin
            case (state)
                WAIT_READY:
                begin
                    // every generator and checker has to report in
                    if ((&gen_ready) && (&check_ready))
                    begin
                        state <= IDLE;
                    end
                end
                IDLE:
                begin
                    // start goes high on the same edge as the command write
                    if (start_req)
                    begin
                        start_q <= 1'b1;
                        cyc_cnt <= '0;
                        elapsed <= '0;
                        results <= '0;
                        state <= RUN;
                    end
                end
                RUN:
                begin
                    results <= check_results;
                    cyc_cnt <= tick_done ? '0 : cyc_cnt + 1'b1;
                    if (tick_done)
                    begin
                        elapsed <= elapsed_nxt;
                        // hand over from start to stop on one edge
                        if (elapsed_nxt == {{(TICKS_W-DURATION_W){1'b0}}, duration})
                        begin
                            start_q <= 1'b0;
                            stop_q <= 1'b1;
                            drain_cnt <= '0;
                            state <= DRAIN;
                        end
                    end
                end
                DRAIN:
                begin
                    // checkers keep receiving, results keep updating
                    results <= check_results;
                    cyc_cnt <= tick_done ? '0 : cyc_cnt + 1'b1;
                    if (tick_done)
                    begin
                        drain_cnt <= drain_nxt;
                        if (drain_nxt == DRAIN_W'(DRAIN_TICKS))
                        begin
                            stop_q <= 1'b0;
                            state <= WAIT_READY;
                        end
                    end
                end
                default:
                begin
                    state <= WAIT_READY;
                end
            endcase
        end
    end

    assign busy = (state != IDLE);
    // same level on every port
    assign start = {PORT_NUM{start_q}};
    assign stop = {PORT_NUM{stop_q}};

endmodule

`default_nettype wire

//--- src/speed_test_top.sv
`default_nettype none

module speed_test_top (
    input  logic                              S_AXI_ACLK,
    input  logic                              S_AXI_ARESETN,
    input  speed_pkg::addr_t                  S_AXI_AWADDR,
    input  logic                              S_AXI_AWVALID,
    output logic                              S_AXI_AWREADY,
    input  speed_pkg::data_t                  S_AXI_WDATA,
    input  logic [speed_pkg::STRB_W-1:0]      S_AXI_WSTRB,
    input  logic                              S_AXI_WVALID,
    output logic                              S_AXI_WREADY,
    output logic [1:0]                        S_AXI_BRESP,
    output logic                              S_AXI_BVALID,
    input  logic                              S_AXI_BREADY,
    input  speed_pkg::addr_t                  S_AXI_ARADDR,
    input  logic                              S_AXI_ARVALID,
    output logic                              S_AXI_ARREADY,
    output speed_pkg::data_t                  S_AXI_RDATA,
    output logic [1:0]                        S_AXI_RRESP,
    output logic                              S_AXI_RVALID,
    input  logic                              S_AXI_RREADY,
    // generators and checkers
    input  logic [speed_pkg::PORT_NUM-1:0]    gen_ready,
    input  logic [speed_pkg::PORT_NUM-1:0]    check_ready,
    input  speed_pkg::res_array_t             check_results,
    output logic [speed_pkg::PORT_NUM-1:0]    start,
    output logic [speed_pkg::PORT_NUM-1:0]    stop,
    output speed_pkg::cfg_array_t             port_config
);
    import speed_pkg::*;

    addr_t rd_addr;
    data_t rd_data;
    logic start_req;
    logic [DURATION_W-1:0] duration;
    logic busy;
    logic [TICKS_W-1:0] elapsed;
    res_array_t results;

    // decoded write from the bus front end
    reg_wr_if wr_bus ();

    axi_lite_slave axi_lite_slave_inst (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WSTRB   (S_AXI_WSTRB),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RRESP   (S_AXI_RRESP),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RREADY  (S_AXI_RREADY),
        .wr            (wr_bus.source),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    ctrl_regs ctrl_regs_inst (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wr            (wr_bus.sink),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .start_req     (start_req),
        .duration      (duration),
        .busy          (busy),
        .elapsed       (elapsed),
        .results       (results),
        .port_config   (port_config)
    );

    test_sequencer test_sequencer_inst (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .start_req     (start_req),
        .duration      (duration),
        .gen_ready     (gen_ready),
        .check_ready   (check_ready),
        .check_results (check_results),
        .busy          (busy),
        .elapsed       (elapsed),
        .results       (results),
        .start         (start),
        .stop          (stop)
    );

endmodule

`default_nettype wire

//--- tests/speed_test_sva.sv
`default_nettype none

module speed_test_sva (
    input logic                            S_AXI_ACLK,
    input logic                            S_AXI_ARESETN,
    input logic                            S_AXI_AWREADY,
    input logic                            S_AXI_WREADY,
    input logic                            S_AXI_BVALID,
    input logic                            S_AXI_BREADY,
    input logic                            S_AXI_RVALID,
    input logic                            S_AXI_RREADY,
    input speed_pkg::data_t                S_AXI_RDATA,
    input logic [speed_pkg::PORT_NUM-1:0]  start,
    input logic [speed_pkg::PORT_NUM-1:0]  stop,
    input speed_pkg::seq_state_t           state
);
    timeunit 1ns;
    timeprecision 1ps;
    import speed_pkg::*;

    // responses hold until the master takes them
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
    else $error("BVALID dropped before BREADY");

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA))
    else $error("RVALID or RDATA changed before RREADY");

    // AW and W ready pulses last one cycle
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (S_AXI_AWREADY || S_AXI_WREADY) |=> !(S_AXI_AWREADY || S_AXI_WREADY))
    else $error("write ready pulse longer than one cycle");

    // start and stop exclusive and equal on all ports with start only in RUN
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        !(start[0] && stop[0]) && ((&start) || !(|start)) && ((&stop) || !(|stop))
        && (!start[0] || (state == RUN)))
    else $error("start and stop levels inconsistent");

    // drain begins on the edge that ends the run
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        $fell(start[0]) |-> $rose(stop[0]))
    else $error("stop did not rise where start fell");

endmodule

bind speed_test_top speed_test_sva speed_test_sva_inst (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_AWREADY (S_AXI_AWREADY),
    .S_AXI_WREADY  (S_AXI_WREADY),
    .S_AXI_BVALID  (S_AXI_BVALID),
    .S_AXI_BREADY  (S_AXI_BREADY),
    .S_AXI_RVALID  (S_AXI_RVALID),
    .S_AXI_RREADY  (S_AXI_RREADY),
    .S_AXI_RDATA   (S_AXI_RDATA),
    .start         (start),
    .stop          (stop),
    .state         (test_sequencer_inst.state)
);

`default_nettype wire

//--- tests/tb_speed_test.sv
`default_nettype none

module tb_speed_test;
    timeunit 1ns;
    timeprecision 1ps;
    import speed_pkg::*;

    localparam int CLK_PERIOD = 8;
    // runs of up to 8 ticks plus drain stay under 500 cycles
    // bus traffic adds about 2500 and the sum is doubled
    localparam int TIMEOUT_CYCLES = 6000;

    logic clk;
    logic rstn;
    addr_t awaddr;
    logic awvalid;
    logic awready;
    data_t wdata;
    logic [STRB_W-1:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    addr_t araddr;
    logic arvalid;
    logic arready;
    data_t rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic [PORT_NUM-1:0] gen_ready;
    logic [PORT_NUM-1:0] check_ready;
    res_array_t check_results;
    logic [PORT_NUM-1:0] start;
    logic [PORT_NUM-1:0] stop;
    cfg_array_t port_config;

    int err_cnt;
    int check_cnt;
    int test_cnt;
    int test_err_base;
    int cycle_cnt;
    int start_len;
    int stop_len;
    data_t cfg_exp [CFG_NUM];
    logic [STRB_W-1:0] strb_val;

    speed_test_top speed_test_top_inst (
        .S_AXI_ACLK    (clk),
        .S_AXI_ARESETN (rstn),
        .S_AXI_AWADDR  (awaddr),
        .S_AXI_AWVALID (awvalid),
        .S_AXI_AWREADY (awready),
        .S_AXI_WDATA   (wdata),
        .S_AXI_WSTRB   (wstrb),
        .S_AXI_WVALID  (wvalid),
        .S_AXI_WREADY  (wready),
        .S_AXI_BRESP   (bresp),
        .S_AXI_BVALID  (bvalid),
        .S_AXI_BREADY  (bready),
        .S_AXI_ARADDR  (araddr),
        .S_AXI_ARVALID (arvalid),
        .S_AXI_ARREADY (arready),
        .S_AXI_RDATA   (rdata),
        .S_AXI_RRESP   (rresp),
        .S_AXI_RVALID  (rvalid),
        .S_AXI_RREADY  (rready),
        .gen_ready     (gen_ready),
        .check_ready   (check_ready),
        .check_results (check_results),
        .start         (start),
        .stop          (stop),
        .port_config   (port_config)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // checker model counts start and stop cycles and shows a result only while active
    always @(posedge clk)
    begin
        #1;
        if (start[0])
        begin
            start_len++;
        end
        if (stop[0])
        begin
            stop_len++;
        end
        for (int p = 0; p < PORT_NUM; p++)
        begin
            if (start[0] || stop[0])
            begin
                check_results[p] = data_t'(p + 1) * (32'h1000_0000 + data_t'(start_len))
                                   + data_t'(stop_len);
            end
            else
            begin
                // idle checkers show junk that must not be sampled
                check_results[p] = 32'hDEAD_0000 + data_t'(p);
            end
        end
    end

    // value a checker shows at the end of the drain after a run of the given ticks
    function automatic data_t expected_result(input int port, input int ticks);
        return data_t'(port + 1) * (32'h1000_0000 + data_t'(ticks * TICK_CYCLES))
               + data_t'(DRAIN_TICKS * TICK_CYCLES);
    endfunction

    // byte lanes with a strobe take the new word
    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input logic [STRB_W-1:0] strb);
        data_t res;
        res = old_word;
        for (int b = 0; b < STRB_W; b++)
        begin
            if (strb[b])
            begin
                res[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_value(input string what, input data_t got, input data_t exp);
        check_cnt++;
        assert (got == exp)
        else
        begin
            $display("ERR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // one write with the response held back for a random number of cycles
    task automatic axi_write(input addr_t addr, input data_t data,
                             input logic [STRB_W-1:0] strb);
        int hold;
        hold = $urandom_range(3, 0);
        awaddr = addr;
        wdata = data;
        wstrb = strb;
        awvalid = 1'b1;
        wvalid = 1'b1;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!awready);
        // handshake completes on this edge
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        while (!bvalid)
        begin
            @(posedge clk);
            #1;
        end
        idle_cycles(hold);
        check_value("BRESP", data_t'(bresp), '0);
        bready = 1'b1;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input addr_t addr, output data_t data);
        int hold;
        hold = $urandom_range(3, 0);
        araddr = addr;
        arvalid = 1'b1;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!arready);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        while (!rvalid)
        begin
            @(posedge clk);
            #1;
        end
        idle_cycles(hold);
        data = rdata;
        check_value("RRESP", data_t'(rresp), '0);
        rready = 1'b1;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic check_read(input addr_t addr, input data_t exp, input string what);
        data_t got;
        axi_read(addr, got);
        check_value(what, got, exp);
    endtask

    // stop rises when the run ends and falls when the drain ends
    task automatic wait_test_done();
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!stop[0]);
        while (stop[0])
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_idle();
        data_t got;
        do
        begin
            axi_read(ADDR_BUSY, got);
        end
        while (got[0]);
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
        test_cnt++;
        test_err_base = err_cnt;
    endtask

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: tests did not finish within %0d cycles", cycle_cnt);
        $display("sim failed");
        $finish;
    end

    initial
    begin
        void'($urandom(36));
        rstn = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        gen_ready = '0;
        check_ready = '0;
        check_results = '0;
        err_cnt = 0;
        check_cnt = 0;
        test_cnt = 0;
        test_err_base = 0;
        start_len = 0;
        stop_len = 0;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;

        // busy stays up until every tester reports ready
        check_value("AWREADY after reset", data_t'(awready), '0);
        check_value("WREADY after reset", data_t'(wready), '0);
        check_value("BVALID after reset", data_t'(bvalid), '0);
        check_value("ARREADY after reset", data_t'(arready), '0);
        check_value("RVALID after reset", data_t'(rvalid), '0);
        gen_ready = '1;
        check_ready = 4'b0101;
        check_read(ADDR_BUSY, 32'h1, "busy with checkers not ready");
        check_value("start before ready", data_t'(start), '0);
        check_value("stop before ready", data_t'(stop), '0);
        check_ready = '1;
        check_read(ADDR_BUSY, 32'h0, "busy with all ready");
        end_test("reset and readiness");

        // full writes first then partial strobes with a lane pattern per word
        for (int i = 0; i < CFG_NUM; i++)
        begin
            cfg_exp[i] = 32'hA5C3_0F00 ^ (32'h0101_0101 * data_t'(i));
            axi_write(ADDR_CFG_BASE + addr_t'(i * 4), cfg_exp[i], 4'hF);
        end
        for (int i = 0; i < CFG_NUM; i++)
        begin
            strb_val = STRB_W'(i * 5);
            axi_write(ADDR_CFG_BASE + addr_t'(i * 4), 32'h1122_3344 + data_t'(i), strb_val);
            cfg_exp[i] = merge_bytes(cfg_exp[i], 32'h1122_3344 + data_t'(i), strb_val);
        end
        for (int i = 0; i < CFG_NUM; i++)
        begin
            check_read(ADDR_CFG_BASE + addr_t'(i * 4), cfg_exp[i], "config readback");
            check_value("port_config word", port_config[i / 2][(i % 2) * DATA_W +: DATA_W],
                        cfg_exp[i]);
        end
        end_test("configuration writes");

        // short run of 3 ticks
        start_len = 0;
        stop_len = 0;
        axi_write(ADDR_DURATION, 32'h0000_0003, 4'b0011);
        axi_write(ADDR_START, 32'h0000_00FF, 4'b0001);
        wait_test_done();
        check_value("start length", data_t'(start_len), data_t'(3 * TICK_CYCLES));
        check_value("stop length", data_t'(stop_len), data_t'(DRAIN_TICKS * TICK_CYCLES));
        check_read(ADDR_DURATION, 32'd3, "elapsed after 3 ticks");
        end_test("start timing");

        // upper bits beyond the 13-bit duration are dropped
        wait_idle();
        start_len = 0;
        stop_len = 0;
        axi_write(ADDR_DURATION, 32'hFFFF_E005, 4'hF);
        axi_write(ADDR_START, 32'h0000_00FF, 4'b0001);
        check_read(ADDR_BUSY, 32'h1, "busy during run");
        // restart attempt while running
        axi_write(ADDR_START, 32'h0000_00FF, 4'b0001);
        wait_test_done();
        check_value("start length", data_t'(start_len), data_t'(5 * TICK_CYCLES));
        check_value("stop length", data_t'(stop_len), data_t'(DRAIN_TICKS * TICK_CYCLES));
        check_read(ADDR_DURATION, 32'd5, "elapsed after 5 ticks");
        wait_idle();
        // wrong key then right key without lane 0 strobe
        axi_write(ADDR_START, 32'h0000_007F, 4'b0001);
        axi_write(ADDR_START, 32'hFFFF_FFFF, 4'b1110);
        idle_cycles(2 * TICK_CYCLES);
        check_value("start after keyless write", data_t'(start_len), data_t'(5 * TICK_CYCLES));
        check_read(ADDR_BUSY, 32'h0, "busy after keyless write");
        end_test("busy during a test");

        for (int p = 0; p < PORT_NUM; p++)
        begin
            check_read(ADDR_RES_BASE + addr_t'(p * 4), expected_result(p, 5), "result word");
        end
        check_read(ADDR_START, 32'h0, "start register read");
        check_read(9'h00C, 32'h0, "unmapped 0x00C");
        check_read(9'h120, 32'h0, "unmapped 0x120");
        check_read(9'h190, 32'h0, "unmapped 0x190");
        check_read(9'h1FC, 32'h0, "unmapped 0x1FC");
        end_test("results and unmapped reads");

        $display("tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
src/speed_pkg.sv
src/reg_wr_if.sv
src/axi_lite_slave.sv
src/ctrl_regs.sv
src/test_sequencer.sv
src/speed_test_top.sv
tests/speed_test_sva.sv
tests/tb_speed_test.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_speed_test -f src.f -o sim_speed_test

status=0
./obj_dir/sim_speed_test > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "sim failed" sim.log; then
    exit 1
fi
